//--- fetch_top.f
hw/fetch_pkg.sv
hw/icache.sv
hw/fetch_ctrl.sv
hw/fetch_top.sv
test/tb_clock.sv
test/mem_model.sv
test/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the fetch stage testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module fetch_tb -f fetch_top.f -o fetch_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/fetch_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

//--- test/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb
  import fetch_pkg::*;
();

  localparam addr_t       RESET_PC = 32'h0000_1000;
  localparam int unsigned WORDS    = 4096;
  localparam int          TIMEOUT  = 200;
  localparam logic [31:0] SEED     = 32'h57a342c6;
  localparam inst_t       INST_JAL = 32'h0100_006f;  // jal x0, +16.

  logic       clk;
  logic       rst;
  addr_t      mem_req_addr;
  logic       mem_req_valid;
  logic       mem_req_ready;
  logic       mem_resp_valid;
  inst_t      mem_resp_data;
  fetch_pkt_t fetch_pkt;
  logic       fetch_valid;
  logic       fetch_ready;
  logic       redirect_valid;
  addr_t      redirect_pc;

  inst_t       image [WORDS];  // what the fetch stage should return per word.
  logic [31:0] rnd_q = SEED;
  int          errors = 0;
  int          checks = 0;

  tb_clock #(.PERIOD_NS (4)) tb_clock_inst (.clk_o (clk));

  mem_model #(.WORDS (WORDS)) mem_model_inst (
    .clk          (clk),
    .rst          (rst),
    .req_addr_i   (mem_req_addr),
    .req_valid_i  (mem_req_valid),
    .req_ready_o  (mem_req_ready),
    .resp_valid_o (mem_resp_valid),
    .resp_data_o  (mem_resp_data),
    .rand_i       (rnd_q)
  );

  fetch_top #(
    .RESET_PC (RESET_PC),
    .INDEX_W  (2)
  ) fetch_top_inst (
    .clk              (clk),
    .rst              (rst),
    .mem_req_addr_o   (mem_req_addr),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_ready_i  (mem_req_ready),
    .mem_resp_valid_i (mem_resp_valid),
    .mem_resp_data_i  (mem_resp_data),
    .fetch_o          (fetch_pkt),
    .fetch_valid_o    (fetch_valid),
    .fetch_ready_i    (fetch_ready),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always @(posedge clk) rnd_q <= xorshift(rnd_q);

  function automatic inst_t addi_word(input addr_t a);
    return {a[13:2], 5'd0, 3'b000, 5'd1, 7'b001_0011};  // addi x1, x0, a[13:2].
  endfunction

  task automatic place_word(input addr_t a, input inst_t w);
    image[a[13:2]] = w;
    mem_model_inst.mem[a[13:2]] = w;
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: %s expected %h, actual %h", name, what, exp, act);
    end
  endtask

  // ############################################################
  // handshake helpers

  task automatic take_packets(input string name, input addr_t first_pc, input int n,
                              input bit random_ready);
    addr_t exp_pc;
    int    got;
    int    idle;
    exp_pc = first_pc;
    got    = 0;
    idle   = 0;
    @(posedge clk);
    fetch_ready <= random_ready ? rnd_q[9] : 1'b1;
    while (got < n && idle < TIMEOUT) begin
      @(posedge clk);
      idle++;
      if (fetch_valid && fetch_ready) begin
        check_value(name, "pc", exp_pc, fetch_pkt.pc);
        check_value(name, "inst", image[exp_pc[13:2]], fetch_pkt.inst);
        exp_pc = exp_pc + 32'd4;
        got++;
        idle = 0;
      end
      if (got < n) begin
        fetch_ready <= random_ready ? rnd_q[9] : 1'b1;
      end
    end
    fetch_ready <= 1'b0;
    if (got < n) begin
      errors++;
      $display("%s: no packet accepted for %0d cycles after %0d of %0d", name, TIMEOUT, got, n);
    end
  endtask

  task automatic wait_for_valid(input string name);
    int waited;
    waited = 0;
    @(posedge clk);
    while (!fetch_valid && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!fetch_valid) begin
      errors++;
      $display("%s: fetch valid never rose within %0d cycles", name, TIMEOUT);
    end
  endtask

  task automatic redirect_to(input addr_t target);
    @(posedge clk);
    redirect_valid <= 1'b1;
    redirect_pc    <= target;
    @(posedge clk);
    redirect_valid <= 1'b0;
  endtask

  // ############################################################
  // directed tests

  task automatic sequential_fetch();
    take_packets("sequential", RESET_PC, 32, 1'b0);
    check_value("sequential", "requests", 32'd16, mem_model_inst.req_count);
    check_value("sequential", "misaligned", 32'd0, mem_model_inst.misaligned_count);
  endtask

  task automatic back_pressure();
    take_packets("back_pressure", 32'h0000_1080, 40, 1'b1);
  endtask

  task automatic control_flow_stall();
    place_word(32'h0000_1140, INST_JAL);
    take_packets("ctrl_flow", 32'h0000_1120, 9, 1'b0);
    checks++;
    repeat (20) begin
      @(posedge clk);
      if (fetch_valid) begin
        errors++;
        $display("ctrl_flow: packet valid at pc %h while waiting for a redirect", fetch_pkt.pc);
      end
    end
    redirect_to(32'h0000_1200);
    take_packets("ctrl_flow", 32'h0000_1200, 8, 1'b0);
  endtask

  task automatic cache_reuse();
    int unsigned c0;
    wait_for_valid("reuse");  // the refill of the next line has to settle first.
    c0 = mem_model_inst.req_count;
    redirect_to(32'h0000_1208);
    take_packets("reuse", 32'h0000_1208, 6, 1'b0);
    check_value("reuse", "requests", c0, mem_model_inst.req_count);
  endtask

  task automatic fence_i_flush();
    int unsigned c0;
    place_word(32'h0000_1228, INST_FENCE_I);
    take_packets("fence_i", 32'h0000_1220, 3, 1'b0);
    c0 = mem_model_inst.req_count;
    wait_for_valid("fence_i");
    check_value("fence_i", "requests", c0 + 1, mem_model_inst.req_count);
    check_value("fence_i", "request addr", 32'h0000_1228, mem_model_inst.last_addr);
    c0 = mem_model_inst.req_count;
    redirect_to(32'h0000_1210);  // was resident before the flush.
    take_packets("fence_i", 32'h0000_1210, 2, 1'b0);
    check_value("fence_i", "requests", c0 + 1, mem_model_inst.req_count);
    check_value("fence_i", "request addr", 32'h0000_1210, mem_model_inst.last_addr);
  endtask

  task automatic conflict_replacement();
    int unsigned c0;
    addr_t       target;
    wait_for_valid("conflict");
    for (int i = 0; i < 4; i++) begin
      target = (i % 2 == 0) ? 32'h0000_1300 : 32'h0000_1700;  // same index, other tag.
      c0 = mem_model_inst.req_count;
      redirect_to(target);
      take_packets("conflict", target, 2, 1'b0);
      check_value("conflict", "requests", c0 + 1, mem_model_inst.req_count);
      check_value("conflict", "request addr", target, mem_model_inst.last_addr);
      wait_for_valid("conflict");
    end
  endtask

  // ############################################################
  // main sequence

  initial begin
    int i;
    rst            = 1'b1;
    fetch_ready    = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    for (i = 0; i < WORDS; i++) begin
      place_word(addr_t'(i << 2), addi_word(addr_t'(i << 2)));
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    sequential_fetch();
    back_pressure();
    control_flow_stall();
    cache_reuse();
    fence_i_flush();
    conflict_replacement();

    repeat (4) @(posedge clk);
    $display("fetch_tb: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #100000;
    $display("fetch_tb: simulation did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- test/mem_model.sv
`timescale 1ns/10ps

module mem_model
  import fetch_pkg::*;
#(
  parameter int unsigned WORDS = 4096
) (
  input  logic        clk,
  input  logic        rst,
  input  addr_t       req_addr_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  output logic        resp_valid_o,
  output inst_t       resp_data_o,
  input  logic [31:0] rand_i
);

  typedef enum logic [1:0] {
    M_IDLE,
    M_BEAT0,
    M_BEAT1
  } mstate_e;

  inst_t       mem [WORDS];  // filled by the testbench.
  int unsigned req_count;
  int unsigned misaligned_count;
  addr_t       last_addr;

  mstate_e    state_q;
  logic [2:0] wait_q;
  addr_t      line_q;

  // 0 to 5 idle cycles.
  function automatic logic [2:0] pick_delay(input logic [31:0] r);
    return 3'(r[7:0] % 8'd6);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q          <= M_IDLE;
      req_ready_o      <= 1'b0;
      resp_valid_o     <= 1'b0;
      resp_data_o      <= '0;
      wait_q           <= 3'd0;
      line_q           <= '0;
      last_addr        <= '0;
      req_count        <= 0;
      misaligned_count <= 0;
    end else begin
      resp_valid_o <= 1'b0;
      case (state_q)
        M_IDLE: begin
          if (req_valid_i && req_ready_o) begin
            req_ready_o <= 1'b0;
            req_count   <= req_count + 1;
            last_addr   <= req_addr_i;
            line_q      <= req_addr_i;
            if (req_addr_i[2:0] != 3'd0) begin
              misaligned_count <= misaligned_count + 1;
            end
            wait_q  <= pick_delay(rand_i);
            state_q <= M_BEAT0;
          end else if (req_valid_i) begin
            if (wait_q == 3'd0) begin
              req_ready_o <= 1'b1;
            end else begin
              wait_q <= wait_q - 3'd1;
            end
          end
        end
        M_BEAT0: begin
          if (wait_q == 3'd0) begin
            resp_valid_o <= 1'b1;
            resp_data_o  <= mem[line_q[13:2]];  // word 0 goes first.
            wait_q       <= pick_delay(rand_i);
            state_q      <= M_BEAT1;
          end else begin
            wait_q <= wait_q - 3'd1;
          end
        end
        default: begin
          if (wait_q == 3'd0) begin
            resp_valid_o <= 1'b1;
            resp_data_o  <= mem[line_q[13:2] + 12'd1];
            wait_q       <= pick_delay(rand_i);  // delay before the next ready.
            state_q      <= M_IDLE;
          end else begin
            wait_q <= wait_q - 3'd1;
          end
        end
      endcase
    end
  end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
  parameter int PERIOD_NS = 4
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/10ps

module fetch_top
  import fetch_pkg::*;
#(
  parameter addr_t       RESET_PC = 32'h0000_1000,
  parameter int unsigned INDEX_W  = 2
) (
  input  logic       clk,
  input  logic       rst,

  // memory bus.
  output addr_t      mem_req_addr_o,
  output logic       mem_req_valid_o,
  input  logic       mem_req_ready_i,
  input  logic       mem_resp_valid_i,
  input  inst_t      mem_resp_data_i,

  // decode side.
  output fetch_pkt_t fetch_o,
  output logic       fetch_valid_o,
  input  logic       fetch_ready_i,

  // execute side.
  input  logic       redirect_valid_i,
  input  addr_t      redirect_pc_i
);

  addr_t lookup_pc;
  logic  lookup_en;
  logic  hit;
  inst_t hit_inst;
  logic  flush;

  fetch_ctrl #(
    .RESET_PC (RESET_PC)
  ) fetch_ctrl_inst (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .lookup_pc_o      (lookup_pc),
    .lookup_en_o      (lookup_en),
    .hit_i            (hit),
    .hit_inst_i       (hit_inst),
    .flush_o          (flush),
    .fetch_o          (fetch_o),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_ready_i    (fetch_ready_i)
  );

  icache #(
    .INDEX_W (INDEX_W)
  ) icache_inst (
    .clk              (clk),
    .rst              (rst),
    .lookup_pc_i      (lookup_pc),
    .lookup_en_i      (lookup_en),
    .hit_o            (hit),
    .hit_inst_o       (hit_inst),
    .flush_i          (flush),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_data_i  (mem_resp_data_i)
  );

endmodule

//--- hw/fetch_ctrl.sv
`timescale 1ns/10ps

module fetch_ctrl
  import fetch_pkg::*;
#(
  parameter addr_t RESET_PC = 32'h0000_1000
) (
  input  logic       clk,
  input  logic       rst,

  input  logic       redirect_valid_i,
  input  addr_t      redirect_pc_i,

  output addr_t      lookup_pc_o,
  output logic       lookup_en_o,
  input  logic       hit_i,
  input  inst_t      hit_inst_i,

  output logic       flush_o,

  output fetch_pkt_t fetch_o,
  output logic       fetch_valid_o,
  input  logic       fetch_ready_i
);

  typedef enum logic {
    RUN,
    WAIT_REDIRECT
  } state_e;

  state_e state_q;
  state_e state_d;
  addr_t  pc_q;
  addr_t  pc_d;

  opcode_t opcode;
  logic    is_ctrl_flow;
  logic    is_fence_i;
  logic    handshake;

  // ############################################################
  // decode of the word under the pc

  assign opcode       = hit_inst_i[OPCODE_W-1:0];
  assign is_ctrl_flow = (opcode == OP_JAL) || (opcode == OP_JALR) ||
                        (opcode == OP_BRANCH) || (opcode == OP_SYSTEM);
  assign is_fence_i   = (hit_inst_i == INST_FENCE_I);

  // ############################################################
  // cache side and downstream

  assign lookup_pc_o = pc_q;
  assign lookup_en_o = (state_q == RUN);  // the cache stays quiet while stalled.

  assign fetch_valid_o = lookup_en_o && hit_i;
  assign fetch_o       = '{pc: pc_q, inst: hit_inst_i};

  assign handshake = fetch_valid_o && fetch_ready_i;

  // one cycle wide since the pc moves on at the same edge.
  assign flush_o = handshake && is_fence_i;

  // ############################################################
  // pc and stall state

  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    if (redirect_valid_i) begin
      // a redirect is taken in any cycle and overrides a handshake.
      state_d = RUN;
      pc_d    = redirect_pc_i;
    end else if (handshake) begin
      if (is_ctrl_flow) begin
        state_d = WAIT_REDIRECT;  // execute owns the next pc.
      end else begin
        pc_d = pc_q + INST_BYTES;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RUN;
      pc_q    <= RESET_PC;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

endmodule

//--- hw/icache.sv
`timescale 1ns/10ps

module icache
  import fetch_pkg::*;
#(
  parameter int unsigned INDEX_W = 2
) (
  input  logic  clk,
  input  logic  rst,

  input  addr_t lookup_pc_i,
  input  logic  lookup_en_i,
  output logic  hit_o,
  output inst_t hit_inst_o,

  input  logic  flush_i,

  output addr_t mem_req_addr_o,
  output logic  mem_req_valid_o,
  input  logic  mem_req_ready_i,

  input  logic  mem_resp_valid_i,
  input  inst_t mem_resp_data_i
);

  // ############################################################
  // geometry

  localparam int unsigned LINES    = 1 << INDEX_W;
  localparam int unsigned OFFSET_W = $clog2(LINE_WORDS);
  localparam int unsigned LINE_LSB = OFFSET_W + BYTE_OFF_W;
  localparam int unsigned TAG_W    = ADDR_W - INDEX_W - LINE_LSB;

  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    BEAT0,
    BEAT1
  } state_e;

  // ############################################################
  // storage

  inst_t            data_q [LINES][LINE_WORDS];
  tag_t             tag_q  [LINES];
  logic [LINES-1:0] valid_q;

  state_e state_q;
  state_e state_d;

  tag_t   miss_tag_q;  // line being refilled.
  index_t miss_idx_q;

  tag_t    lookup_tag;
  index_t  lookup_idx;
  offset_t lookup_off;

  logic miss;
  logic beat0_we;
  logic refill_done;

  // ############################################################
  // lookup

  assign lookup_tag = lookup_pc_i[ADDR_W-1 -: TAG_W];
  assign lookup_idx = lookup_pc_i[LINE_LSB +: INDEX_W];
  assign lookup_off = lookup_pc_i[BYTE_OFF_W +: OFFSET_W];

  // no hits while a refill is in flight, so a half written line is never seen.
  assign hit_o = (state_q == IDLE) && valid_q[lookup_idx] &&
                 (tag_q[lookup_idx] == lookup_tag);

  assign hit_inst_o = data_q[lookup_idx][lookup_off];

  assign miss = lookup_en_i && (state_q == IDLE) && !hit_o;

  // ############################################################
  // refill

  assign mem_req_valid_o = (state_q == REQ);
  assign mem_req_addr_o  = {miss_tag_q, miss_idx_q, {LINE_LSB{1'b0}}};

  assign beat0_we    = (state_q == BEAT0) && mem_resp_valid_i;
  assign refill_done = (state_q == BEAT1) && mem_resp_valid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (miss) begin
          state_d = REQ;
        end
      end
      REQ: begin
        if (mem_req_ready_i) begin
          state_d = BEAT0;
        end
      end
      BEAT0: begin
        if (mem_resp_valid_i) begin
          state_d = BEAT1;
        end
      end
      BEAT1: begin
        if (mem_resp_valid_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      valid_q <= '0;
    end else begin
      state_q <= state_d;
      if (flush_i) begin
        valid_q <= '0;
      end
      if (refill_done) begin
        valid_q[miss_idx_q] <= 1'b1;  // wins over a flush in the same cycle.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (miss) begin
      miss_tag_q <= lookup_tag;
      miss_idx_q <= lookup_idx;
    end
    if (beat0_we) begin
      data_q[miss_idx_q][offset_t'(0)] <= mem_resp_data_i;
    end
    if (refill_done) begin
      data_q[miss_idx_q][offset_t'(1)] <= mem_resp_data_i;
      tag_q[miss_idx_q]               <= miss_tag_q;
    end
  end

endmodule

//--- hw/fetch_pkg.sv
package fetch_pkg;

  // ############################################################
  // widths and basic types

  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned INST_W     = 32;
  localparam int unsigned OPCODE_W   = 7;
  localparam int unsigned BYTE_OFF_W = 2;  // byte offset inside one word.

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [INST_W-1:0]   inst_t;
  typedef logic [OPCODE_W-1:0] opcode_t;

  // the line geometry is fixed, only the number of lines varies.
  localparam int unsigned LINE_WORDS = 2;

  localparam addr_t INST_BYTES = addr_t'(1 << BYTE_OFF_W);

  // ############################################################
  // RV32 encodings

  localparam opcode_t OP_JAL    = 7'b110_1111;
  localparam opcode_t OP_JALR   = 7'b110_0111;
  localparam opcode_t OP_BRANCH = 7'b110_0011;
  localparam opcode_t OP_SYSTEM = 7'b111_0011;

  // fence.i with rd, rs1 and imm all zero.
  localparam inst_t INST_FENCE_I = 32'h0000_100f;

  // ############################################################
  // downstream packet

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_pkt_t;

endpackage
